/* Bender.yml */
package:
  name: exu_dispatch

sources:
  - files:
      - src/exu_dispatch_pkg.sv
      - src/inst_dispatcher.sv
      - src/rd_scoreboard.sv
      - src/mul_unit.sv
      - src/div_unit.sv
      - src/wb_arbiter.sv
      - src/exu_dispatch_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/exu_dispatch_sva.sv
      - tb/tb_exu_dispatch_top.sv

/* sim.f */
src/exu_dispatch_pkg.sv
src/inst_dispatcher.sv
src/rd_scoreboard.sv
src/mul_unit.sv
src/div_unit.sv
src/wb_arbiter.sv
src/exu_dispatch_top.sv
tb/tb_clk_gen.sv
tb/exu_dispatch_sva.sv
tb/tb_exu_dispatch_top.sv

/* src/div_unit.sv */
`default_nettype none

module div_unit (
	input wire clk,
	input wire rst_n,
	input wire exu_dispatch_pkg::op33_t op_a, // dividend
	input wire exu_dispatch_pkg::op33_t op_b, // divisor
	input wire rem_sel, // 1 returns the remainder
	input wire exu_dispatch_pkg::rd_id_t rd_id,
	input wire valid,
	output logic ready,
	output exu_dispatch_pkg::xlen_t res_data,
	output exu_dispatch_pkg::rd_id_t res_rd_id,
	output logic res_valid,
	input wire res_ready
);

	exu_dispatch_pkg::div_state_e state;
	logic [5:0] cnt; // step counter
	logic [32:0] a_mag, b_mag; // operand magnitudes
	logic [32:0] dvs, quo, rem; // divisor, quotient/dividend shifter, partial rem
	logic neg_q, neg_r, rem_q;
	logic [33:0] shifted; // partial rem with next dividend bit
	logic [34:0] diff; // msb is the borrow
	logic [32:0] quo_s, rem_s;

	assign a_mag = op_a[32] ? -op_a : op_a;
	assign b_mag = op_b[32] ? -op_b : op_b;
	assign shifted = {rem, quo[32]};
	assign diff = {1'b0, shifted} - {2'b0, dvs};
	assign quo_s = neg_q ? -quo : quo;
	assign rem_s = neg_r ? -rem : rem; // remainder follows the dividend
	assign ready = (state == exu_dispatch_pkg::DIV_IDLE);
	assign res_valid = (state == exu_dispatch_pkg::DIV_DONE);
	assign res_data = rem_q ? rem_s[31:0] : quo_s[31:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= exu_dispatch_pkg::DIV_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				exu_dispatch_pkg::DIV_IDLE: if (valid) begin
					state <= exu_dispatch_pkg::DIV_BUSY;
					cnt <= '0;
				end
				exu_dispatch_pkg::DIV_BUSY: begin
					cnt <= cnt + 6'd1;
					if (cnt == 6'(exu_dispatch_pkg::DIV_STEPS - 1))
						state <= exu_dispatch_pkg::DIV_DONE;
				end
				exu_dispatch_pkg::DIV_DONE: if (res_ready)
					state <= exu_dispatch_pkg::DIV_IDLE; // result taken
				default: state <= exu_dispatch_pkg::DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == exu_dispatch_pkg::DIV_IDLE && valid) begin
			quo <= a_mag;
			rem <= '0;
			dvs <= b_mag;
			// divide by zero: quotient stays all ones, rem ends as the dividend
			neg_q <= (op_a[32] ^ op_b[32]) & (|op_b);
			neg_r <= op_a[32];
			rem_q <= rem_sel;
			res_rd_id <= rd_id;
		end else if (state == exu_dispatch_pkg::DIV_BUSY) begin
			quo <= {quo[31:0], ~diff[34]}; // restoring step
			rem <= diff[34] ? shifted[32:0] : diff[32:0];
		end
	end

endmodule

`default_nettype wire

/* src/exu_dispatch_pkg.sv */
`default_nettype none

package exu_dispatch_pkg;

	typedef logic [31:0] xlen_t; // data word, pc, operand, result
	typedef logic [4:0] rd_id_t; // register index
	typedef logic [32:0] op33_t; // sign/zero extended mul/div operand
	typedef logic [3:0] alu_op_t; // alu operation code
	typedef logic [2:0] ls_type_t; // load/store access type
	typedef logic [11:0] csr_addr_t; // csr address
	typedef logic [1:0] csr_upd_t; // csr update type
	typedef logic [6:0] inst_type_t; // one flag per instruction class
	typedef logic [70:0] reuse_msg_t; // overlaid dispatch payload

	// instruction type flag positions
	localparam int FLAG_B = 6;
	localparam int FLAG_CSR = 5;
	localparam int FLAG_LOAD = 4;
	localparam int FLAG_STORE = 3;
	localparam int FLAG_MUL = 2;
	localparam int FLAG_DIV = 1;
	localparam int FLAG_REM = 0;

	// payload field offsets, layout depends on the instruction class
	localparam int ALU_MODE_OFS = 64; // alu op code, 4 bits
	localparam int ALU_OP1_OFS = 32;
	localparam int ALU_OP2_OFS = 0;
	localparam int LS_TYPE_OFS = 68; // only for load/store
	localparam int PRDT_JUMP_OFS = 68; // only for branches, same bit as ls type lsb
	localparam int CSR_ADDR_OFS = 34;
	localparam int CSR_TYPE_OFS = 32;
	localparam int CSR_MASK_OFS = 0;
	localparam int MD_OP_A_OFS = 34; // 33 bit operand a
	localparam int MD_OP_B_OFS = 1; // 33 bit operand b
	localparam int MD_RES_SEL_OFS = 0; // mul high word select

	typedef enum logic [1:0] {DIV_IDLE, DIV_BUSY, DIV_DONE} div_state_e;

	localparam int DIV_STEPS = 33; // one quotient bit per step

endpackage

`default_nettype wire

/* src/exu_dispatch_top.sv */
`default_nettype none

module exu_dispatch_top (
	input wire clk,
	input wire rst_n,
	input wire sys_reset_req,
	input wire flush_req,
	input wire exu_dispatch_pkg::reuse_msg_t s_dispatch_req_msg_reused,
	input wire exu_dispatch_pkg::inst_type_t s_dispatch_req_inst_type_packeted,
	input wire exu_dispatch_pkg::xlen_t s_dispatch_req_pc_of_inst,
	input wire exu_dispatch_pkg::xlen_t s_dispatch_req_pc_jump,
	input wire exu_dispatch_pkg::rd_id_t s_dispatch_req_rd_id,
	input wire s_dispatch_req_rd_vld,
	input wire s_dispatch_req_valid,
	output logic s_dispatch_req_ready,
	output exu_dispatch_pkg::alu_op_t m_alu_op_mode,
	output exu_dispatch_pkg::xlen_t m_alu_op1,
	output exu_dispatch_pkg::xlen_t m_alu_op2,
	output logic m_alu_addr_gen_sel,
	output logic m_alu_valid,
	input wire m_alu_ready,
	output exu_dispatch_pkg::xlen_t m_bcu_pc_of_inst,
	output exu_dispatch_pkg::xlen_t m_bcu_pc_jump,
	output logic m_bcu_prdt_jump,
	output logic m_bcu_valid,
	input wire m_bcu_ready,
	output logic m_ls_sel,
	output exu_dispatch_pkg::ls_type_t m_ls_type,
	output exu_dispatch_pkg::rd_id_t m_rd_id_for_ld,
	output logic m_lsu_valid,
	input wire m_lsu_ready,
	output exu_dispatch_pkg::csr_addr_t m_csr_addr,
	output exu_dispatch_pkg::csr_upd_t m_csr_upd_type,
	output exu_dispatch_pkg::xlen_t m_csr_upd_mask_v,
	output logic m_csr_rw_valid,
	input wire m_csr_rw_ready,
	input wire ld_done, // load completion from the lsu
	input wire exu_dispatch_pkg::rd_id_t ld_done_rd_id,
	output logic wb_valid,
	output exu_dispatch_pkg::rd_id_t wb_rd_id,
	output exu_dispatch_pkg::xlen_t wb_data,
	input wire wb_ready
);

	exu_dispatch_pkg::rd_id_t chk_rd_id, m_mul_rd_id, m_div_rd_id, set_rd_id;
	exu_dispatch_pkg::op33_t m_mul_op_a, m_mul_op_b, m_div_op_a, m_div_op_b;
	exu_dispatch_pkg::xlen_t mul_data, div_data;
	exu_dispatch_pkg::rd_id_t mul_rd_id, div_rd_id;
	logic rd_raw_dpc, set_en;
	logic m_mul_res_sel, m_mul_valid, m_mul_ready, m_div_rem_sel, m_div_valid, m_div_ready;
	logic mul_valid, mul_ready, div_valid, div_ready;

	// at most one of these transfers happens per cycle
	assign set_en = (m_mul_valid & m_mul_ready) | (m_div_valid & m_div_ready) |
		(m_lsu_valid & m_lsu_ready & ~m_ls_sel);
	assign set_rd_id = chk_rd_id; // every long instruction takes rd from the request

	inst_dispatcher u_disp (
		.raw_dpc_check_rd_id(chk_rd_id),
		.*
	);

	rd_scoreboard u_sb (
		.clk, .rst_n, .chk_rd_id, .rd_busy(rd_raw_dpc), .set_en, .set_rd_id,
		.wb_clr_en(wb_valid & wb_ready), .wb_clr_rd_id(wb_rd_id), .ld_done, .ld_done_rd_id
	);

	mul_unit u_mul (
		.clk, .rst_n, .op_a(m_mul_op_a), .op_b(m_mul_op_b), .res_sel(m_mul_res_sel),
		.rd_id(m_mul_rd_id), .valid(m_mul_valid), .ready(m_mul_ready),
		.res_data(mul_data), .res_rd_id(mul_rd_id), .res_valid(mul_valid), .res_ready(mul_ready)
	);

	div_unit u_div (
		.clk, .rst_n, .op_a(m_div_op_a), .op_b(m_div_op_b), .rem_sel(m_div_rem_sel),
		.rd_id(m_div_rd_id), .valid(m_div_valid), .ready(m_div_ready),
		.res_data(div_data), .res_rd_id(div_rd_id), .res_valid(div_valid), .res_ready(div_ready)
	);

	wb_arbiter u_arb (
		.mul_data, .mul_rd_id, .mul_valid, .mul_ready, .div_data, .div_rd_id, .div_valid,
		.div_ready, .wb_valid, .wb_rd_id, .wb_data, .wb_ready
	);

endmodule

`default_nettype wire

/* src/inst_dispatcher.sv */
`default_nettype none

module inst_dispatcher (
	input wire sys_reset_req,
	input wire flush_req,
	output exu_dispatch_pkg::rd_id_t raw_dpc_check_rd_id, // rd looked up in scoreboard
	input wire rd_raw_dpc, // rd still owed by a long instruction
	input wire exu_dispatch_pkg::reuse_msg_t s_dispatch_req_msg_reused,
	input wire exu_dispatch_pkg::inst_type_t s_dispatch_req_inst_type_packeted,
	input wire exu_dispatch_pkg::xlen_t s_dispatch_req_pc_of_inst,
	input wire exu_dispatch_pkg::xlen_t s_dispatch_req_pc_jump,
	input wire exu_dispatch_pkg::rd_id_t s_dispatch_req_rd_id,
	input wire s_dispatch_req_rd_vld,
	input wire s_dispatch_req_valid,
	output logic s_dispatch_req_ready,
	output exu_dispatch_pkg::alu_op_t m_alu_op_mode,
	output exu_dispatch_pkg::xlen_t m_alu_op1,
	output exu_dispatch_pkg::xlen_t m_alu_op2,
	output logic m_alu_addr_gen_sel, // alu computes a memory address
	output logic m_alu_valid,
	input wire m_alu_ready,
	output exu_dispatch_pkg::xlen_t m_bcu_pc_of_inst,
	output exu_dispatch_pkg::xlen_t m_bcu_pc_jump,
	output logic m_bcu_prdt_jump,
	output logic m_bcu_valid,
	input wire m_bcu_ready,
	output logic m_ls_sel, // 0 load, 1 store
	output exu_dispatch_pkg::ls_type_t m_ls_type,
	output exu_dispatch_pkg::rd_id_t m_rd_id_for_ld,
	output logic m_lsu_valid,
	input wire m_lsu_ready,
	output exu_dispatch_pkg::csr_addr_t m_csr_addr,
	output exu_dispatch_pkg::csr_upd_t m_csr_upd_type,
	output exu_dispatch_pkg::xlen_t m_csr_upd_mask_v,
	output logic m_csr_rw_valid,
	input wire m_csr_rw_ready,
	output exu_dispatch_pkg::op33_t m_mul_op_a,
	output exu_dispatch_pkg::op33_t m_mul_op_b,
	output logic m_mul_res_sel, // 0 low word, 1 high word
	output exu_dispatch_pkg::rd_id_t m_mul_rd_id,
	output logic m_mul_valid,
	input wire m_mul_ready,
	output exu_dispatch_pkg::op33_t m_div_op_a,
	output exu_dispatch_pkg::op33_t m_div_op_b,
	output logic m_div_rem_sel, // 0 quotient, 1 remainder
	output exu_dispatch_pkg::rd_id_t m_div_rd_id,
	output logic m_div_valid,
	input wire m_div_ready
);

	logic on_flush_rst, waw_hold, go; // go: request may leave this cycle
	logic is_b, is_csr, is_st, is_ls, is_mul, is_dr, no_alu;
	logic pair_rdy; // partner of a paired alu transfer is ready

	assign is_b = s_dispatch_req_inst_type_packeted[exu_dispatch_pkg::FLAG_B];
	assign is_csr = s_dispatch_req_inst_type_packeted[exu_dispatch_pkg::FLAG_CSR];
	assign is_st = s_dispatch_req_inst_type_packeted[exu_dispatch_pkg::FLAG_STORE];
	assign is_ls = s_dispatch_req_inst_type_packeted[exu_dispatch_pkg::FLAG_LOAD] | is_st;
	assign is_mul = s_dispatch_req_inst_type_packeted[exu_dispatch_pkg::FLAG_MUL];
	assign is_dr = s_dispatch_req_inst_type_packeted[exu_dispatch_pkg::FLAG_DIV] |
		s_dispatch_req_inst_type_packeted[exu_dispatch_pkg::FLAG_REM];
	assign no_alu = is_csr | is_mul | is_dr; // these bypass the alu

	assign on_flush_rst = sys_reset_req | flush_req;
	assign raw_dpc_check_rd_id = s_dispatch_req_rd_id;
	assign waw_hold = s_dispatch_req_rd_vld & rd_raw_dpc; // rd owed, wait
	assign go = s_dispatch_req_valid & ~on_flush_rst & ~waw_hold;
	// branch and load/store move alu plus partner in the same cycle
	assign pair_rdy = (~is_b | m_bcu_ready) & (~is_ls | m_lsu_ready) &
		(~(is_b | is_ls) | m_alu_ready);

	assign s_dispatch_req_ready = ~on_flush_rst & ~waw_hold &
		(no_alu | m_alu_ready) & (~is_b | m_bcu_ready) & (~is_ls | m_lsu_ready) &
		(~is_csr | m_csr_rw_ready) & (~is_mul | m_mul_ready) & (~is_dr | m_div_ready);

	assign m_alu_op_mode = s_dispatch_req_msg_reused[exu_dispatch_pkg::ALU_MODE_OFS +: 4];
	assign m_alu_op1 = s_dispatch_req_msg_reused[exu_dispatch_pkg::ALU_OP1_OFS +: 32];
	assign m_alu_op2 = s_dispatch_req_msg_reused[exu_dispatch_pkg::ALU_OP2_OFS +: 32];
	assign m_alu_addr_gen_sel = is_ls;
	assign m_alu_valid = go & ~no_alu & pair_rdy;

	assign m_bcu_pc_of_inst = s_dispatch_req_pc_of_inst;
	assign m_bcu_pc_jump = s_dispatch_req_pc_jump;
	assign m_bcu_prdt_jump = s_dispatch_req_msg_reused[exu_dispatch_pkg::PRDT_JUMP_OFS];
	assign m_bcu_valid = go & is_b & pair_rdy;

	assign m_ls_sel = is_st;
	assign m_ls_type = s_dispatch_req_msg_reused[exu_dispatch_pkg::LS_TYPE_OFS +: 3];
	assign m_rd_id_for_ld = s_dispatch_req_rd_id;
	assign m_lsu_valid = go & is_ls & pair_rdy;

	assign m_csr_addr = s_dispatch_req_msg_reused[exu_dispatch_pkg::CSR_ADDR_OFS +: 12];
	assign m_csr_upd_type = s_dispatch_req_msg_reused[exu_dispatch_pkg::CSR_TYPE_OFS +: 2];
	assign m_csr_upd_mask_v = s_dispatch_req_msg_reused[exu_dispatch_pkg::CSR_MASK_OFS +: 32];
	assign m_csr_rw_valid = go & is_csr;

	// mul and div share the operand fields of the payload
	assign m_mul_op_a = s_dispatch_req_msg_reused[exu_dispatch_pkg::MD_OP_A_OFS +: 33];
	assign m_mul_op_b = s_dispatch_req_msg_reused[exu_dispatch_pkg::MD_OP_B_OFS +: 33];
	assign m_mul_res_sel = s_dispatch_req_msg_reused[exu_dispatch_pkg::MD_RES_SEL_OFS];
	assign m_mul_rd_id = s_dispatch_req_rd_id;
	assign m_mul_valid = go & is_mul;

	assign m_div_op_a = m_mul_op_a;
	assign m_div_op_b = m_mul_op_b;
	assign m_div_rem_sel = s_dispatch_req_inst_type_packeted[exu_dispatch_pkg::FLAG_REM];
	assign m_div_rd_id = s_dispatch_req_rd_id;
	assign m_div_valid = go & is_dr;

endmodule

`default_nettype wire

/* src/mul_unit.sv */
`default_nettype none

module mul_unit (
	input wire clk,
	input wire rst_n,
	input wire exu_dispatch_pkg::op33_t op_a,
	input wire exu_dispatch_pkg::op33_t op_b,
	input wire res_sel, // 1 selects the high word
	input wire exu_dispatch_pkg::rd_id_t rd_id,
	input wire valid,
	output logic ready,
	output exu_dispatch_pkg::xlen_t res_data,
	output exu_dispatch_pkg::rd_id_t res_rd_id,
	output logic res_valid,
	input wire res_ready
);

	logic s1_valid, s2_valid; // stage occupancy
	logic s1_adv, s2_adv; // stage may load
	logic signed [65:0] s1_prod; // full 33x33 product
	logic s1_sel;
	exu_dispatch_pkg::rd_id_t s1_rd;

	assign s2_adv = ~s2_valid | res_ready; // empty or draining
	assign s1_adv = ~s1_valid | s2_adv;
	assign ready = s1_adv; // low only when both full and output stuck
	assign res_valid = s2_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (s1_adv)
				s1_valid <= valid;
			if (s2_adv)
				s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_adv & valid) begin
			s1_prod <= $signed(op_a) * $signed(op_b);
			s1_sel <= res_sel;
			s1_rd <= rd_id;
		end
		if (s2_adv & s1_valid) begin
			res_data <= s1_sel ? s1_prod[63:32] : s1_prod[31:0]; // mulh* vs mul
			res_rd_id <= s1_rd;
		end
	end

endmodule

`default_nettype wire

/* src/rd_scoreboard.sv */
`default_nettype none

module rd_scoreboard (
	input wire clk,
	input wire rst_n,
	input wire exu_dispatch_pkg::rd_id_t chk_rd_id, // rd of the waiting instruction
	output logic rd_busy,
	input wire set_en, // long instruction accepted
	input wire exu_dispatch_pkg::rd_id_t set_rd_id,
	input wire wb_clr_en, // writeback transfer
	input wire exu_dispatch_pkg::rd_id_t wb_clr_rd_id,
	input wire ld_done, // load data returned
	input wire exu_dispatch_pkg::rd_id_t ld_done_rd_id
);

	logic [31:0] busy; // one bit per register
	logic [31:0] set_mask, clr_mask, busy_nxt;

	always_comb begin
		set_mask = '0;
		clr_mask = '0;
		if (set_en)
			set_mask[set_rd_id] = 1'b1;
		if (wb_clr_en)
			clr_mask[wb_clr_rd_id] = 1'b1;
		if (ld_done)
			clr_mask[ld_done_rd_id] = 1'b1;
		// set after clear, newer instruction owns the register
		busy_nxt = (busy & ~clr_mask) | set_mask;
		busy_nxt[0] = 1'b0; // x0 is never owed
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			busy <= '0;
		else
			busy <= busy_nxt;
	end

	assign rd_busy = busy[chk_rd_id]; // same cycle lookup

endmodule

`default_nettype wire

/* src/wb_arbiter.sv */
`default_nettype none

module wb_arbiter (
	input wire exu_dispatch_pkg::xlen_t mul_data,
	input wire exu_dispatch_pkg::rd_id_t mul_rd_id,
	input wire mul_valid,
	output logic mul_ready,
	input wire exu_dispatch_pkg::xlen_t div_data,
	input wire exu_dispatch_pkg::rd_id_t div_rd_id,
	input wire div_valid,
	output logic div_ready,
	output logic wb_valid,
	output exu_dispatch_pkg::rd_id_t wb_rd_id,
	output exu_dispatch_pkg::xlen_t wb_data,
	input wire wb_ready
);

	logic div_gnt; // divider holds the port

	// divider first, it blocks its unit for the whole division
	assign div_gnt = div_valid;
	assign wb_valid = div_valid | mul_valid;
	assign wb_rd_id = div_gnt ? div_rd_id : mul_rd_id;
	assign wb_data = div_gnt ? div_data : mul_data;

	assign div_ready = wb_ready;
	assign mul_ready = wb_ready & ~div_gnt; // loser sees back-pressure

endmodule

`default_nettype wire

/* tb/exu_dispatch_sva.sv */
`default_nettype none

module exu_dispatch_sva (
	input wire clk,
	input wire rst_n,
	input wire flush_req,
	input wire m_alu_valid,
	input wire m_bcu_valid,
	input wire m_lsu_valid,
	input wire m_csr_rw_valid,
	input wire wb_valid,
	input wire wb_ready,
	input wire exu_dispatch_pkg::rd_id_t wb_rd_id,
	input wire exu_dispatch_pkg::xlen_t wb_data
);

	timeunit 1ns;
	timeprecision 100ps;

	// nothing leaves toward the external units during a flush
	no_valid_on_flush: assert property (@(posedge clk) disable iff (!rst_n)
		flush_req |-> !(m_alu_valid | m_bcu_valid | m_lsu_valid | m_csr_rw_valid))
		else $error("outward valid asserted during flush");

	wb_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_valid && !wb_ready) |=> ($stable(wb_data) && $stable(wb_rd_id)))
		else $error("writeback payload changed while stalled");

	bcu_needs_alu: assert property (@(posedge clk) disable iff (!rst_n)
		m_bcu_valid |-> m_alu_valid) // branch pair moves together
		else $error("bcu valid without alu valid");

endmodule

bind exu_dispatch_top exu_dispatch_sva u_sva (.*);

`default_nettype wire

/* tb/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk); // hold reset 5 cycles
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* tb/tb_exu_dispatch_top.sv */
`default_nettype none

module tb_exu_dispatch_top;

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		exu_dispatch_pkg::inst_type_t typ;
		exu_dispatch_pkg::reuse_msg_t msg;
		logic [3:0] rdy; // alu, bcu, lsu, csr
		logic flush;
		logic rst_req;
		logic exp_rdy;
		logic [3:0] exp_v; // alu, bcu, lsu, csr
	} row_t;

	logic clk, rst_n, sys_reset_req, flush_req, s_dispatch_req_rd_vld, s_dispatch_req_valid;
	exu_dispatch_pkg::reuse_msg_t s_dispatch_req_msg_reused;
	exu_dispatch_pkg::inst_type_t s_dispatch_req_inst_type_packeted;
	exu_dispatch_pkg::xlen_t s_dispatch_req_pc_of_inst, s_dispatch_req_pc_jump;
	exu_dispatch_pkg::rd_id_t s_dispatch_req_rd_id, ld_done_rd_id, m_rd_id_for_ld, wb_rd_id;
	logic s_dispatch_req_ready, m_alu_addr_gen_sel, m_alu_valid, m_alu_ready;
	exu_dispatch_pkg::alu_op_t m_alu_op_mode;
	exu_dispatch_pkg::xlen_t m_alu_op1, m_alu_op2, m_bcu_pc_of_inst, m_bcu_pc_jump;
	logic m_bcu_prdt_jump, m_bcu_valid, m_bcu_ready, m_ls_sel, m_lsu_valid, m_lsu_ready;
	exu_dispatch_pkg::ls_type_t m_ls_type;
	exu_dispatch_pkg::csr_addr_t m_csr_addr;
	exu_dispatch_pkg::csr_upd_t m_csr_upd_type;
	exu_dispatch_pkg::xlen_t m_csr_upd_mask_v, wb_data;
	logic m_csr_rw_valid, m_csr_rw_ready, ld_done, wb_valid, wb_ready;
	row_t rows[$];
	exu_dispatch_pkg::xlen_t md_a[$], md_b[$];
	int md_kind[$]; // 0 mul low, 1 mul high, 2 div, 3 rem

	tb_clk_gen u_clk (.clk, .rst_n);

	exu_dispatch_top dut (.*);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_xlen(input string name, input exu_dispatch_pkg::xlen_t got,
		input exu_dispatch_pkg::xlen_t exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_rd(input string name, input exu_dispatch_pkg::rd_id_t got,
		input exu_dispatch_pkg::rd_id_t exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_flags(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
		end
	endtask

	// low or high word of the signed product
	function automatic exu_dispatch_pkg::xlen_t mul_ref(input exu_dispatch_pkg::xlen_t a,
		input exu_dispatch_pkg::xlen_t b, input bit hi);
		logic signed [63:0] p;
		p = 64'($signed(a)) * 64'($signed(b));
		return hi ? p[63:32] : p[31:0];
	endfunction

	function automatic exu_dispatch_pkg::xlen_t div_ref(input exu_dispatch_pkg::xlen_t a,
		input exu_dispatch_pkg::xlen_t b, input bit rem);
		int q, r;
		if (b == 0)
			return rem ? a : 32'hffff_ffff; // riscv divide by zero
		if (a == 32'h8000_0000 && b == 32'hffff_ffff)
			return rem ? 32'h0 : a; // overflow case
		q = $signed(a) / $signed(b); // truncates toward zero
		r = $signed(a) % $signed(b); // sign of dividend
		return rem ? r : q;
	endfunction

	function automatic exu_dispatch_pkg::reuse_msg_t md_msg(input exu_dispatch_pkg::xlen_t a,
		input exu_dispatch_pkg::xlen_t b, input bit hi);
		return {4'h0, a[31], a, b[31], b, hi}; // 33 bit sign extended operands
	endfunction

	task automatic add_row(input exu_dispatch_pkg::inst_type_t typ, input logic [3:0] rdy,
		input logic fl, input logic rq, input logic er, input logic [3:0] ev);
		row_t r;
		r.typ = typ;
		r.msg = exu_dispatch_pkg::reuse_msg_t'({$urandom, $urandom, $urandom});
		r.rdy = rdy;
		r.flush = fl;
		r.rst_req = rq;
		r.exp_rdy = er;
		r.exp_v = ev;
		rows.push_back(r);
	endtask

	// present an instruction and hold it until accepted
	task automatic send(input exu_dispatch_pkg::inst_type_t typ,
		input exu_dispatch_pkg::reuse_msg_t msg, input exu_dispatch_pkg::rd_id_t rd);
		int i;
		@(posedge clk);
		s_dispatch_req_inst_type_packeted <= typ;
		s_dispatch_req_msg_reused <= msg;
		s_dispatch_req_rd_id <= rd;
		s_dispatch_req_rd_vld <= 1'b1;
		s_dispatch_req_valid <= 1'b1;
		for (i = 0; i < 200; i++) begin
			@(negedge clk);
			if (s_dispatch_req_ready)
				break;
		end
		if (i == 200)
			fail_run("timeout: instruction was never accepted");
		@(posedge clk); // handshake on this edge
		s_dispatch_req_valid <= 1'b0;
	endtask

	// poll for a writeback transfer and compare it
	task automatic wait_wb(input exu_dispatch_pkg::xlen_t exp_d,
		input exu_dispatch_pkg::rd_id_t exp_rd);
		int i;
		for (i = 0; i < 200; i++) begin
			@(negedge clk);
			if (wb_valid && wb_ready)
				break;
		end
		if (i == 200)
			fail_run("timeout: no writeback arrived");
		check_xlen("wb_data", wb_data, exp_d);
		check_rd("wb_rd_id", wb_rd_id, exp_rd);
		@(posedge clk);
	endtask

	task automatic present(input exu_dispatch_pkg::inst_type_t typ,
		input exu_dispatch_pkg::rd_id_t rd, input logic vld);
		@(posedge clk);
		s_dispatch_req_inst_type_packeted <= typ;
		s_dispatch_req_rd_id <= rd;
		s_dispatch_req_rd_vld <= vld;
		s_dispatch_req_valid <= 1'b1;
		@(negedge clk);
	endtask

	initial begin
		int i, k;
		row_t r;
		exu_dispatch_pkg::xlen_t exp_d, exp_m;
		exu_dispatch_pkg::inst_type_t ty;
		void'($urandom(32'ha3e2));
		sys_reset_req = 1'b0;
		flush_req = 1'b0;
		s_dispatch_req_msg_reused = '0;
		s_dispatch_req_inst_type_packeted = '0;
		s_dispatch_req_pc_of_inst = '0;
		s_dispatch_req_pc_jump = '0;
		s_dispatch_req_rd_id = '0;
		s_dispatch_req_rd_vld = 1'b0;
		s_dispatch_req_valid = 1'b0;
		{m_alu_ready, m_bcu_ready, m_lsu_ready, m_csr_rw_ready} = 4'hf;
		ld_done = 1'b0;
		ld_done_rd_id = '0;
		wb_ready = 1'b1;

		add_row(7'h00, 4'hf, 0, 0, 1, 4'b1000); // plain alu
		add_row(7'h40, 4'hf, 0, 0, 1, 4'b1100); // branch
		add_row(7'h40, 4'hb, 0, 0, 0, 4'b0000); // branch with bcu busy
		add_row(7'h40, 4'h7, 0, 0, 0, 4'b0000); // branch with alu busy
		add_row(7'h10, 4'hf, 0, 0, 1, 4'b1010); // load
		add_row(7'h08, 4'hd, 0, 0, 0, 4'b0000); // store with lsu busy
		add_row(7'h08, 4'hf, 0, 0, 1, 4'b1010); // store
		add_row(7'h20, 4'hf, 0, 0, 1, 4'b0001); // csr
		add_row(7'h20, 4'h7, 0, 0, 1, 4'b0001); // csr ignores alu
		add_row(7'h20, 4'he, 0, 0, 0, 4'b0001); // csr unit busy
		add_row(7'h00, 4'h9, 0, 0, 1, 4'b1000); // alu ignores bcu and lsu
		add_row(7'h00, 4'hf, 1, 0, 0, 4'b0000); // flush
		add_row(7'h40, 4'hf, 0, 1, 0, 4'b0000); // reset request

		for (i = 0; i < 200 && !rst_n; i++)
			@(posedge clk);
		if (!rst_n)
			fail_run("timeout: reset never released");

		foreach (rows[n]) begin
			r = rows[n];
			@(posedge clk);
			s_dispatch_req_inst_type_packeted <= r.typ;
			s_dispatch_req_msg_reused <= r.msg;
			s_dispatch_req_pc_of_inst <= $urandom;
			s_dispatch_req_pc_jump <= $urandom;
			s_dispatch_req_rd_id <= '0; // x0 keeps loads off the scoreboard
			s_dispatch_req_rd_vld <= 1'b1;
			s_dispatch_req_valid <= 1'b1;
			{m_alu_ready, m_bcu_ready, m_lsu_ready, m_csr_rw_ready} <= r.rdy;
			flush_req <= r.flush;
			sys_reset_req <= r.rst_req;
			@(negedge clk);
			check_ready("s_dispatch_req_ready", s_dispatch_req_ready, r.exp_rdy);
			check_flags("valids", {m_alu_valid, m_bcu_valid, m_lsu_valid, m_csr_rw_valid},
				r.exp_v);
			check_xlen("m_alu_op_mode", 32'(m_alu_op_mode), 32'(r.msg[67:64]));
			check_xlen("m_alu_op1", m_alu_op1, r.msg[63:32]);
			check_xlen("m_alu_op2", m_alu_op2, r.msg[31:0]);
			check_xlen("m_ls_type", 32'(m_ls_type), 32'(r.msg[70:68]));
			check_xlen("m_bcu_prdt_jump", 32'(m_bcu_prdt_jump), 32'(r.msg[68]));
			check_xlen("m_bcu_pc_of_inst", m_bcu_pc_of_inst, s_dispatch_req_pc_of_inst);
			check_xlen("m_bcu_pc_jump", m_bcu_pc_jump, s_dispatch_req_pc_jump);
			check_xlen("m_csr_addr", 32'(m_csr_addr), 32'(r.msg[45:34]));
			check_xlen("m_csr_upd_type", 32'(m_csr_upd_type), 32'(r.msg[33:32]));
			check_xlen("m_csr_upd_mask_v", m_csr_upd_mask_v, r.msg[31:0]);
			check_ready("m_ls_sel", m_ls_sel, r.typ[3]);
			check_ready("m_alu_addr_gen_sel", m_alu_addr_gen_sel, r.typ[4] | r.typ[3]);
		end
		@(posedge clk);
		s_dispatch_req_valid <= 1'b0;
		flush_req <= 1'b0;
		sys_reset_req <= 1'b0;
		{m_alu_ready, m_bcu_ready, m_lsu_ready, m_csr_rw_ready} <= 4'hf;

		// random and corner case mul/div operands
		md_a = '{$urandom, $urandom, 32'hffff_ffff, 32'h8000_0000, $urandom, $urandom,
			$urandom, $urandom, 32'h8000_0000, 32'h8000_0000, 32'hffff_fff9};
		md_b = '{$urandom, $urandom, 32'hffff_ffff, 32'h8000_0000, $urandom % 1000 + 1,
			$urandom, 32'h0, 32'h0, 32'hffff_ffff, 32'hffff_ffff, 32'h2};
		md_kind = '{0, 1, 1, 1, 2, 3, 2, 3, 2, 3, 3};
		foreach (md_kind[n]) begin
			k = md_kind[n];
			ty = (k < 2) ? 7'h04 : ((k == 2) ? 7'h02 : 7'h01);
			exp_d = (k < 2) ? mul_ref(md_a[n], md_b[n], k == 1) :
				div_ref(md_a[n], md_b[n], k == 3);
			send(ty, md_msg(md_a[n], md_b[n], k == 1), 5'(n + 10));
			wait_wb(exp_d, 5'(n + 10));
		end

		// rd owed by a divide
		send(7'h02, md_msg(32'd100, 32'd7, 0), 5'd5);
		present(7'h00, 5'd5, 1'b1);
		check_ready("s_dispatch_req_ready", s_dispatch_req_ready, 1'b0);
		present(7'h00, 5'd5, 1'b0); // no rd written
		check_ready("s_dispatch_req_ready", s_dispatch_req_ready, 1'b1);
		present(7'h00, 5'd0, 1'b1);
		check_ready("s_dispatch_req_ready", s_dispatch_req_ready, 1'b1);
		present(7'h00, 5'd5, 1'b1);
		wait_wb(32'd14, 5'd5);
		present(7'h00, 5'd5, 1'b1);
		check_ready("s_dispatch_req_ready", s_dispatch_req_ready, 1'b1);

		// rd owed by a load
		send(7'h10, '0, 5'd7);
		present(7'h00, 5'd7, 1'b1);
		check_ready("s_dispatch_req_ready", s_dispatch_req_ready, 1'b0);
		check_rd("m_rd_id_for_ld", m_rd_id_for_ld, 5'd7);
		@(posedge clk);
		s_dispatch_req_valid <= 1'b0;
		ld_done <= 1'b1;
		ld_done_rd_id <= 5'd7;
		@(posedge clk);
		ld_done <= 1'b0;
		present(7'h00, 5'd7, 1'b1);
		check_ready("s_dispatch_req_ready", s_dispatch_req_ready, 1'b1);

		// both units finish under back-pressure
		@(posedge clk);
		s_dispatch_req_valid <= 1'b0;
		wb_ready <= 1'b0;
		exp_d = div_ref(32'hffff_ff00, 32'd9, 0);
		exp_m = mul_ref(32'h1234_5678, 32'hfedc_ba98, 1);
		send(7'h02, md_msg(32'hffff_ff00, 32'd9, 0), 5'd20);
		for (i = 0; i < 200 && !wb_valid; i++)
			@(negedge clk);
		if (!wb_valid)
			fail_run("timeout: divider never finished");
		send(7'h04, md_msg(32'h1234_5678, 32'hfedc_ba98, 1), 5'd21);
		repeat (3) @(posedge clk); // multiplier latency is two cycles
		wb_ready <= 1'b1;
		wait_wb(exp_d, 5'd20);
		wait_wb(exp_m, 5'd21);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
